//--- verilog/tcp_tx_pkg.sv
package tcp_tx_pkg;

  typedef logic [3:0][7:0] ipv4_t;
  typedef logic [5:0][7:0] mac_t;
  typedef logic [15:0]     port_t;
  typedef logic [31:0]     tcp_num_t;

  typedef struct packed {
    ipv4_t    ipv4_addr; // remote side
    mac_t     mac_addr;
    port_t    loc_port;
    port_t    rem_port;
    tcp_num_t loc_ack;
  } tcb_t;

  typedef struct packed {
    ipv4_t ipv4_addr;
    mac_t  mac_addr;
  } dev_t;

  typedef enum logic [1:0] {
    tcp_closed,
    tcp_syn_sent,
    tcp_connected,
    tcp_fin_wait
  } tcp_stat_t;

  typedef struct packed {
    mac_t        dst_mac;
    mac_t        src_mac;
    logic [15:0] ethertype;
  } mac_hdr_t;

  typedef struct packed {
    logic [3:0]  ver;
    logic [3:0]  ihl;
    logic [7:0]  qos;
    logic [15:0] length;
    logic [15:0] id;
    logic        zero;
    logic        df;
    logic        mf;
    logic [12:0] fo;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] cks;
    ipv4_t       src_ip;
    ipv4_t       dst_ip;
  } ipv4_hdr_t;

  // checksum logic walks the words, builders fill the fields
  typedef union packed {
    ipv4_hdr_t        hdr;
    logic [9:0][15:0] words;
  } ipv4_hdr_u;

  typedef struct packed {
    port_t       src_port;
    port_t       dst_port;
    tcp_num_t    tcp_seq_num;
    tcp_num_t    tcp_ack_num;
    logic [3:0]  tcp_offset;
    logic [2:0]  tcp_rsvd;
    logic [8:0]  tcp_flags;
    logic [15:0] tcp_wnd_size;
    logic [15:0] tcp_cks;
    logic [15:0] tcp_pointer;
  } tcp_hdr_t;

  typedef struct packed {
    mac_hdr_t    mac_hdr;
    ipv4_hdr_u   ipv4_hdr;
    tcp_hdr_t    tcp_hdr;
    logic [15:0] pld_len;
    logic [15:0] pld_cks;
  } tcp_meta_t;

  typedef struct packed {
    tcp_num_t    seq;
    logic [15:0] lng;
    logic [15:0] cks;
  } tcp_pld_info_t;

  typedef struct packed {
    logic      rdy;
    tcp_meta_t meta;
  } tx_req_t;

  typedef struct packed {
    logic acc;
    logic done;
  } tx_rsp_t;

  localparam logic [8:0]  TCP_FLAG_FIN = 9'h001;
  localparam logic [8:0]  TCP_FLAG_SYN = 9'h002;
  localparam logic [8:0]  TCP_FLAG_RST = 9'h004;
  localparam logic [8:0]  TCP_FLAG_PSH = 9'h008;
  localparam logic [8:0]  TCP_FLAG_ACK = 9'h010;
  localparam logic [3:0]  TCP_DEFAULT_OFFSET  = 4'd5;
  localparam logic [15:0] DEFAULT_WINDOW_SIZE = 16'd1000;
  localparam logic [7:0]  IPV4_TTL       = 8'd64;
  localparam logic [7:0]  PROTO_TCP      = 8'd6;
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam int          HDR_WORDS      = 27;
  localparam int          PLD_Q_DEPTH    = 4;

  // id and ip checksum are left zero, the serializer fills them in
  function automatic tcp_meta_t build_meta(
    input tcb_t        tcb,
    input dev_t        dev,
    input logic [8:0]  flags,
    input tcp_num_t    seq,
    input tcp_num_t    ack,
    input logic [15:0] pld_len,
    input logic [15:0] pld_cks
  );
    tcp_meta_t m;
    m = '0;
    m.mac_hdr.dst_mac          = tcb.mac_addr;
    m.mac_hdr.src_mac          = dev.mac_addr;
    m.mac_hdr.ethertype        = ETHERTYPE_IPV4;
    m.ipv4_hdr.hdr.ver         = 4'd4;
    m.ipv4_hdr.hdr.ihl         = 4'd5;
    m.ipv4_hdr.hdr.length      = pld_len + 16'd40; // 20 ip + 20 tcp
    m.ipv4_hdr.hdr.df          = 1'b1;
    m.ipv4_hdr.hdr.ttl         = IPV4_TTL;
    m.ipv4_hdr.hdr.proto       = PROTO_TCP;
    m.ipv4_hdr.hdr.src_ip      = dev.ipv4_addr;
    m.ipv4_hdr.hdr.dst_ip      = tcb.ipv4_addr;
    m.tcp_hdr.src_port         = tcb.loc_port;
    m.tcp_hdr.dst_port         = tcb.rem_port;
    m.tcp_hdr.tcp_seq_num      = seq;
    m.tcp_hdr.tcp_ack_num      = ack;
    m.tcp_hdr.tcp_offset       = TCP_DEFAULT_OFFSET;
    m.tcp_hdr.tcp_flags        = flags;
    m.tcp_hdr.tcp_wnd_size     = DEFAULT_WINDOW_SIZE;
    m.pld_len                  = pld_len;
    m.pld_cks                  = pld_cks;
    return m;
  endfunction

endpackage

//--- verilog/tcp_tx_pld_track.sv
`timescale 1ns/1ps

module tcp_tx_pld_track (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      pld_push,
  input  logic [15:0]               pld_push_lng,
  input  logic [15:0]               pld_push_cks,
  input  logic                      pld_sent,
  input  logic                      seq_bump,
  output logic                      send_pld,
  output tcp_tx_pkg::tcp_pld_info_t pld_info,
  output tcp_tx_pkg::tcp_num_t      loc_seq,
  output logic                      pld_full
);

  import tcp_tx_pkg::*;

  tcp_pld_info_t queue [PLD_Q_DEPTH];

  logic [$clog2(PLD_Q_DEPTH)-1:0] wr_ptr;
  logic [$clog2(PLD_Q_DEPTH)-1:0] rd_ptr;
  logic [$clog2(PLD_Q_DEPTH):0]   count;
  tcp_num_t                       tail_seq; // loc_seq plus all queued lengths
  tcp_num_t                       next_tail;
  logic                           push_ok;
  logic                           pop;

  assign pld_full  = (count == PLD_Q_DEPTH);
  assign send_pld  = (count != 0);
  assign pld_info  = queue[rd_ptr];
  assign push_ok   = pld_push && !pld_full;
  assign pop       = pld_sent && send_pld;
  assign next_tail = tail_seq + {31'd0, seq_bump};

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      loc_seq  <= 32'h1000;
      tail_seq <= 32'h1000;
    end else begin
      if (push_ok) begin
        wr_ptr   <= wr_ptr + 1'b1;
        tail_seq <= next_tail + {16'd0, pld_push_lng};
      end else begin
        tail_seq <= next_tail;
      end
      if (pop) begin
        rd_ptr  <= rd_ptr + 1'b1;
        loc_seq <= loc_seq + {16'd0, queue[rd_ptr].lng} + {31'd0, seq_bump};
      end else begin
        loc_seq <= loc_seq + {31'd0, seq_bump}; // SYN/FIN take one number
      end
      case ({push_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      queue[wr_ptr].seq <= next_tail;
      queue[wr_ptr].lng <= pld_push_lng;
      queue[wr_ptr].cks <= pld_push_cks;
    end
  end

  a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
    pld_full |-> !pld_push)
    else $error("payload descriptor dropped, queue full");

endmodule

//--- verilog/tcp_ctl_tx.sv
`timescale 1ns/1ps

module tcp_ctl_tx (
  input  logic                 clk,
  input  logic                 rst,
  input  tcp_tx_pkg::tcb_t     tcb,
  input  tcp_tx_pkg::dev_t     dev,
  input  tcp_tx_pkg::tcp_num_t loc_seq,
  input  logic                 ctl_send,
  input  logic [8:0]           ctl_flags,
  input  tcp_tx_pkg::tx_rsp_t  ctl_rsp,
  output tcp_tx_pkg::tx_req_t  ctl_req,
  output logic                 ctl_sent,
  output logic                 seq_bump
);

  import tcp_tx_pkg::*;

  enum logic {idle_s, active_s} state;

  logic     ctl_rdy;
  logic     bump_flag; // SYN or FIN in the latched segment
  tcp_num_t ack_num;

  assign ack_num      = ((ctl_flags & TCP_FLAG_ACK) != '0) ? tcb.loc_ack : '0;
  assign ctl_req.rdy  = ctl_rdy;
  assign bump_flag    = (ctl_req.meta.tcp_hdr.tcp_flags & (TCP_FLAG_SYN | TCP_FLAG_FIN)) != '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle_s;
      ctl_rdy  <= 1'b0;
      ctl_sent <= 1'b0;
      seq_bump <= 1'b0;
    end else begin
      ctl_sent <= 1'b0;
      seq_bump <= 1'b0;
      case (state)
        idle_s: begin
          if (ctl_send && !ctl_sent) begin // skip the cycle the user sees ctl_sent
            ctl_rdy <= 1'b1;
            state   <= active_s;
          end
        end
        active_s: begin
          if (ctl_rsp.acc) ctl_rdy <= 1'b0;
          if (ctl_rsp.done) begin
            ctl_sent <= 1'b1;
            seq_bump <= bump_flag;
            state    <= idle_s;
          end
        end
        default: state <= idle_s;
      endcase
    end
  end

  // meta follows the inputs while idle and freezes once rdy is up
  always_ff @(posedge clk) begin
    if (state == idle_s) begin
      ctl_req.meta <= build_meta(tcb, dev, ctl_flags, loc_seq, ack_num, 16'd0, 16'd0);
    end
  end

  a_rdy_until_acc: assert property (@(posedge clk) disable iff (rst)
    ctl_req.rdy && !ctl_rsp.acc |=> ctl_req.rdy)
    else $error("control request dropped before acceptance");

endmodule

//--- verilog/tcp_tx_arb.sv
`timescale 1ns/1ps

module tcp_tx_arb (
  input  logic                      clk,
  input  logic                      rst,
  input  tcp_tx_pkg::tcb_t          tcb,
  input  tcp_tx_pkg::dev_t          dev,
  input  tcp_tx_pkg::tcp_stat_t     status,
  input  logic                      send_pld,
  input  tcp_tx_pkg::tcp_pld_info_t pld_info,
  input  logic                      send_ka,
  input  logic                      send_ack,
  input  tcp_tx_pkg::tcp_num_t      loc_seq,
  input  tcp_tx_pkg::tx_req_t       ctl_req,
  input  tcp_tx_pkg::tx_rsp_t       out_rsp,
  output tcp_tx_pkg::tx_req_t       out_req,
  output tcp_tx_pkg::tx_rsp_t       ctl_rsp,
  output logic                      pld_sent,
  output logic                      ka_sent,
  output logic                      ack_sent
);

  import tcp_tx_pkg::*;

  enum logic [1:0] {
    tx_none,
    tx_pld,
    tx_ka,
    tx_ack
  } kind;

  enum logic {idle_s, active_s} state;

  tx_req_t arb_req;
  tx_rsp_t arb_rsp;
  logic    sent_any;
  logic    frame_busy; // between acc and done on the shared path
  logic    any_req;

  assign sent_any = pld_sent | ka_sent | ack_sent;
  assign any_req  = send_pld | send_ka | send_ack;

  always_comb begin
    if (status == tcp_connected) begin
      out_req = arb_req;
      arb_rsp = out_rsp;
      ctl_rsp = '0;
    end else begin
      out_req = ctl_req; // control segments own the header path
      ctl_rsp = out_rsp;
      arb_rsp = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= idle_s;
      kind        <= tx_none;
      arb_req.rdy <= 1'b0;
      pld_sent    <= 1'b0;
      ka_sent     <= 1'b0;
      ack_sent    <= 1'b0;
      frame_busy  <= 1'b0;
    end else begin
      pld_sent <= 1'b0;
      ka_sent  <= 1'b0;
      ack_sent <= 1'b0;
      if (out_rsp.acc) frame_busy <= 1'b1;
      else if (out_rsp.done) frame_busy <= 1'b0;
      case (state)
        idle_s: begin
          // a sent pulse means the queue head or request level is still stale
          if (status == tcp_connected && !sent_any && any_req) begin
            arb_req.rdy <= 1'b1;
            state       <= active_s;
            if (send_pld) kind <= tx_pld;
            else if (send_ka) kind <= tx_ka;
            else kind <= tx_ack;
          end
        end
        active_s: begin
          if (arb_rsp.acc) arb_req.rdy <= 1'b0;
          if (arb_rsp.done) begin
            state <= idle_s;
            kind  <= tx_none;
            case (kind)
              tx_pld:  pld_sent <= 1'b1;
              tx_ka:   ka_sent  <= 1'b1;
              tx_ack:  ack_sent <= 1'b1;
              default: ;
            endcase
          end
        end
        default: state <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle_s) begin
      if (send_pld) begin
        arb_req.meta <= build_meta(tcb, dev, TCP_FLAG_PSH | TCP_FLAG_ACK, pld_info.seq,
                                   tcb.loc_ack, pld_info.lng, pld_info.cks);
      end else if (send_ka) begin
        arb_req.meta <= build_meta(tcb, dev, TCP_FLAG_ACK, loc_seq - 1, tcb.loc_ack,
                                   16'd0, 16'd0); // keep-alive probes one below
      end else begin
        arb_req.meta <= build_meta(tcb, dev, TCP_FLAG_ACK, loc_seq, tcb.loc_ack,
                                   16'd0, 16'd0);
      end
    end
  end

  a_no_rdy_in_frame: assert property (@(posedge clk) disable iff (rst)
    $rose(out_req.rdy) |-> !frame_busy)
    else $error("new request raised while a frame is active");

endmodule

//--- verilog/tcp_hdr_ser.sv
`timescale 1ns/1ps

module tcp_hdr_ser (
  input  logic                clk,
  input  logic                rst,
  input  tcp_tx_pkg::tx_req_t in_req,
  output tcp_tx_pkg::tx_rsp_t in_rsp,
  output logic [15:0]         hdr_word,
  output logic                hdr_valid,
  output logic                hdr_last
);

  import tcp_tx_pkg::*;

  enum logic [1:0] {ser_idle, ser_cks, ser_shift} state;

  tcp_meta_t               meta_q;
  ipv4_hdr_u               ip_out;
  logic [HDR_WORDS*16-1:0] shreg;
  logic [4:0]              word_cnt;
  logic [15:0]             id_cnt;
  logic                    acc_q;
  logic [19:0]             cks_sum;
  logic [16:0]             cks_fold;

  // ones' complement sum, cks field is zero in meta_q
  always_comb begin
    cks_sum = '0;
    for (int i = 0; i < $bits(ipv4_hdr_t) / 16; i++) begin
      cks_sum = cks_sum + {4'd0, meta_q.ipv4_hdr.words[i]};
    end
    cks_fold       = {1'b0, cks_sum[15:0]} + {13'd0, cks_sum[19:16]};
    ip_out         = meta_q.ipv4_hdr;
    ip_out.hdr.cks = ~(cks_fold[15:0] + {15'd0, cks_fold[16]});
  end

  assign hdr_word    = shreg[HDR_WORDS*16-1 -: 16]; // msw first
  assign hdr_last    = hdr_valid && (word_cnt == HDR_WORDS);
  assign in_rsp.acc  = acc_q;
  assign in_rsp.done = hdr_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ser_idle;
      acc_q     <= 1'b0;
      hdr_valid <= 1'b0;
      word_cnt  <= '0;
      id_cnt    <= '0;
    end else begin
      acc_q <= 1'b0;
      case (state)
        ser_idle: begin
          if (in_req.rdy) begin
            acc_q  <= 1'b1;
            id_cnt <= id_cnt + 1'b1;
            state  <= ser_cks;
          end
        end
        ser_cks: begin
          hdr_valid <= 1'b1;
          word_cnt  <= 5'd1;
          state     <= ser_shift;
        end
        ser_shift: begin
          if (word_cnt == HDR_WORDS) begin
            hdr_valid <= 1'b0;
            word_cnt  <= '0;
            state     <= ser_idle;
          end else begin
            word_cnt <= word_cnt + 1'b1;
          end
        end
        default: state <= ser_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ser_idle && in_req.rdy) begin
      meta_q                  <= in_req.meta;
      meta_q.ipv4_hdr.hdr.id  <= id_cnt;
      meta_q.ipv4_hdr.hdr.cks <= '0;
    end
    if (state == ser_cks) shreg <= {meta_q.mac_hdr, ip_out, meta_q.tcp_hdr};
    else if (state == ser_shift) shreg <= shreg << 16;
  end

endmodule

//--- verilog/tcp_tx_top.sv
`timescale 1ns/1ps

module tcp_tx_top (
  input  logic                  clk,
  input  logic                  rst,
  input  tcp_tx_pkg::tcb_t      tcb,
  input  tcp_tx_pkg::dev_t      dev,
  input  tcp_tx_pkg::tcp_stat_t status,
  input  logic                  pld_push,
  input  logic [15:0]           pld_push_lng,
  input  logic [15:0]           pld_push_cks,
  input  logic                  send_ka,
  input  logic                  send_ack,
  input  logic                  ctl_send,
  input  logic [8:0]            ctl_flags,
  output logic                  ka_sent,
  output logic                  ack_sent,
  output logic                  pld_sent,
  output logic                  ctl_sent,
  output logic                  pld_full,
  output logic [15:0]           hdr_word,
  output logic                  hdr_valid,
  output logic                  hdr_last
);

  import tcp_tx_pkg::*;

  tcp_pld_info_t pld_info;
  tcp_num_t      loc_seq;
  logic          send_pld;
  logic          seq_bump;
  tx_req_t       ctl_req;
  tx_rsp_t       ctl_rsp;
  tx_req_t       out_req;
  tx_rsp_t       out_rsp;

  tcp_tx_pld_track tcp_tx_pld_track_i (
    .clk          (clk),
    .rst          (rst),
    .pld_push     (pld_push),
    .pld_push_lng (pld_push_lng),
    .pld_push_cks (pld_push_cks),
    .pld_sent     (pld_sent),
    .seq_bump     (seq_bump),
    .send_pld     (send_pld),
    .pld_info     (pld_info),
    .loc_seq      (loc_seq),
    .pld_full     (pld_full)
  );

  tcp_ctl_tx tcp_ctl_tx_i (
    .clk       (clk),
    .rst       (rst),
    .tcb       (tcb),
    .dev       (dev),
    .loc_seq   (loc_seq),
    .ctl_send  (ctl_send),
    .ctl_flags (ctl_flags),
    .ctl_rsp   (ctl_rsp),
    .ctl_req   (ctl_req),
    .ctl_sent  (ctl_sent),
    .seq_bump  (seq_bump)
  );

  tcp_tx_arb tcp_tx_arb_i (
    .clk      (clk),
    .rst      (rst),
    .tcb      (tcb),
    .dev      (dev),
    .status   (status),
    .send_pld (send_pld),
    .pld_info (pld_info),
    .send_ka  (send_ka),
    .send_ack (send_ack),
    .loc_seq  (loc_seq),
    .ctl_req  (ctl_req),
    .out_rsp  (out_rsp),
    .out_req  (out_req),
    .ctl_rsp  (ctl_rsp),
    .pld_sent (pld_sent),
    .ka_sent  (ka_sent),
    .ack_sent (ack_sent)
  );

  tcp_hdr_ser tcp_hdr_ser_i (
    .clk       (clk),
    .rst       (rst),
    .in_req    (out_req),
    .in_rsp    (out_rsp),
    .hdr_word  (hdr_word),
    .hdr_valid (hdr_valid),
    .hdr_last  (hdr_last)
  );

endmodule

//--- dv/tcp_tx_tb.sv
`timescale 1ns/1ps

module tcp_tx_tb;

  import tcp_tx_pkg::*;

  localparam int NUM_FRAMES  = 14;
  localparam int TIMEOUT_CYC = 40 * NUM_FRAMES + 100;
  localparam int HDR_BITS    = HDR_WORDS * 16;

  typedef struct packed {
    logic [3:0]  pulse; // {ctl, pld, ka, ack}
    logic [8:0]  flags;
    tcp_num_t    seq;
    tcp_num_t    ack;
    logic [15:0] len;
  } frame_exp_t;

  logic        clk;
  logic        rst;
  tcb_t        tcb;
  dev_t        dev;
  tcp_stat_t   status;
  logic        pld_push;
  logic [15:0] pld_push_lng;
  logic [15:0] pld_push_cks;
  logic        send_ka;
  logic        send_ack;
  logic        ctl_send;
  logic [8:0]  ctl_flags;
  logic        ka_sent;
  logic        ack_sent;
  logic        pld_sent;
  logic        ctl_sent;
  logic        pld_full;
  logic [15:0] hdr_word;
  logic        hdr_valid;
  logic        hdr_last;

  integer        seed = 90;
  int            err_cnt = 0;
  int            err_mark = 0;
  int            pass_cnt = 0;
  int            fail_cnt = 0;
  int            cyc = 0;
  int            frame_cnt = 0;
  int            last_end = -100;
  int            wcnt = 0;
  bit            in_frame = 0;
  bit            pend_valid = 0;
  logic [3:0]    pend_pulse;
  string         pend_name;
  logic [HDR_BITS-1:0] act_hdr;
  tcp_num_t      tail_seq = 32'h1000; // loc_seq once all queued payloads are sent
  frame_exp_t    exp_q[$];
  string         name_q[$];

  // expected 27 header words, word 0 in the top bits
  function automatic logic [HDR_BITS-1:0] ref_header(input tcb_t t, input dev_t d,
                                                     input frame_exp_t e, input logic [15:0] id);
    logic [15:0]         ip [10];
    logic [15:0]         tw [10];
    logic [31:0]         sum;
    logic [31:0]         sip;
    logic [31:0]         dip;
    logic [HDR_BITS-1:0] r;
    int                  i;
    sip   = d.ipv4_addr;
    dip   = t.ipv4_addr;
    ip[0] = 16'h4500; // version 4, ihl 5
    ip[1] = e.len + 16'd40;
    ip[2] = id;
    ip[3] = 16'h4000; // DF set, no fragment offset
    ip[4] = 16'h4006; // ttl 64, proto tcp
    ip[5] = 16'h0000;
    ip[6] = sip[31:16];
    ip[7] = sip[15:0];
    ip[8] = dip[31:16];
    ip[9] = dip[15:0];
    sum = 32'd0;
    for (i = 0; i < 10; i++) sum = sum + {16'd0, ip[i]};
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    ip[5] = ~sum[15:0];
    tw[0] = t.loc_port;
    tw[1] = t.rem_port;
    tw[2] = e.seq[31:16];
    tw[3] = e.seq[15:0];
    tw[4] = e.ack[31:16];
    tw[5] = e.ack[15:0];
    tw[6] = {4'd5, 3'd0, e.flags};
    tw[7] = 16'd1000;
    tw[8] = 16'h0000; // tcp checksum not computed
    tw[9] = 16'h0000;
    r = '0;
    r[111:0] = {t.mac_addr, d.mac_addr, 16'h0800};
    for (i = 0; i < 10; i++) r = {r[HDR_BITS-17:0], ip[i]};
    for (i = 0; i < 10; i++) r = {r[HDR_BITS-17:0], tw[i]};
    return r;
  endfunction

  task automatic mac_hdr_cmp(input string name, input mac_hdr_t exp, input mac_hdr_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %s mac header: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic ipv4_hdr_cmp(input string name, input ipv4_hdr_t exp, input ipv4_hdr_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %s ipv4 header: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic tcp_hdr_cmp(input string name, input tcp_hdr_t exp, input tcp_hdr_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %s tcp header: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic sent_kind_cmp(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %s sent pulses {ctl,pld,ka,ack}: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic full_flag_cmp(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %s pld_full: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic expect_frame(input string name, input logic [3:0] pulse, input logic [8:0] flags,
                              input tcp_num_t seq, input tcp_num_t ack, input logic [15:0] len);
    exp_q.push_back('{pulse: pulse, flags: flags, seq: seq, ack: ack, len: len});
    name_q.push_back(name);
  endtask

  task automatic push_payload(input string name);
    logic [31:0] rnd;
    logic [15:0] lng;
    rnd = $random(seed);
    lng = {6'd0, rnd[9:0]} + 16'd1;
    rnd = $random(seed);
    @(posedge clk);
    pld_push     <= 1'b1;
    pld_push_lng <= lng;
    pld_push_cks <= rnd[15:0];
    expect_frame(name, 4'b0100, TCP_FLAG_PSH | TCP_FLAG_ACK, tail_seq, tcb.loc_ack, lng);
    tail_seq = tail_seq + {16'd0, lng};
  endtask

  // drops each user level on its sent pulse, returns after n pulses in mask
  task automatic wait_pulses(input logic [3:0] mask, input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(posedge clk);
      if (ka_sent) send_ka <= 1'b0;
      if (ack_sent) send_ack <= 1'b0;
      if (ctl_sent) ctl_send <= 1'b0;
      if (({ctl_sent, pld_sent, ka_sent, ack_sent} & mask) != 4'b0) seen++;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    @(negedge clk);
    errs     = err_cnt - err_mark;
    err_mark = err_cnt;
    if (errs == 0) begin
      pass_cnt++;
      $display("test %s ok", name);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", name, errs);
    end
  endtask

  tcp_tx_top tcp_tx_top_i (
    .clk          (clk),
    .rst          (rst),
    .tcb          (tcb),
    .dev          (dev),
    .status       (status),
    .pld_push     (pld_push),
    .pld_push_lng (pld_push_lng),
    .pld_push_cks (pld_push_cks),
    .send_ka      (send_ka),
    .send_ack     (send_ack),
    .ctl_send     (ctl_send),
    .ctl_flags    (ctl_flags),
    .ka_sent      (ka_sent),
    .ack_sent     (ack_sent),
    .pld_sent     (pld_sent),
    .ctl_sent     (ctl_sent),
    .pld_full     (pld_full),
    .hdr_word     (hdr_word),
    .hdr_valid    (hdr_valid),
    .hdr_last     (hdr_last)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin : watchdog
    while (cyc < TIMEOUT_CYC) @(posedge clk);
    $display("run stopped after %0d cycles, a frame or sent pulse never came", cyc);
    $display("SIMULATION FAILED");
    $finish;
  end

  always @(posedge clk) begin : collect
    logic [3:0]          pulses;
    logic [HDR_BITS-1:0] exp_hdr;
    frame_exp_t          e;
    string               nm;
    if (!rst) begin
      pulses = {ctl_sent, pld_sent, ka_sent, ack_sent};
      if (pend_valid) begin
        sent_kind_cmp(pend_name, pend_pulse, pulses);
        pend_valid = 0;
      end else if (pulses != 4'b0) begin
        err_cnt++;
        $display("sent pulse %b seen without a finished frame", pulses);
      end
      if (hdr_valid) begin
        if (!in_frame) begin
          in_frame = 1;
          wcnt     = 0;
          if (exp_q.size() == 0) begin
            err_cnt++;
            $display("a frame started while none was expected");
          end
          if (cyc <= last_end + 1) begin
            err_cnt++;
            $display("a frame started before the previous sent pulse");
          end
        end
        act_hdr = {act_hdr[HDR_BITS-17:0], hdr_word};
        wcnt++;
        if (hdr_last) begin
          in_frame = 0;
          last_end = cyc;
          if (wcnt != HDR_WORDS) begin
            err_cnt++;
            $display("hdr_last came on word %0d instead of word %0d", wcnt, HDR_WORDS);
          end
          if (exp_q.size() != 0) begin
            e       = exp_q.pop_front();
            nm      = name_q.pop_front();
            exp_hdr = ref_header(tcb, dev, e, frame_cnt[15:0]);
            mac_hdr_cmp(nm, exp_hdr[HDR_BITS-1 -: 112], act_hdr[HDR_BITS-1 -: 112]);
            ipv4_hdr_cmp(nm, exp_hdr[HDR_BITS-113 -: 160], act_hdr[HDR_BITS-113 -: 160]);
            tcp_hdr_cmp(nm, exp_hdr[159:0], act_hdr[159:0]);
            pend_valid = 1;
            pend_pulse = e.pulse;
            pend_name  = nm;
          end
          frame_cnt++;
        end else if (wcnt == HDR_WORDS) begin
          err_cnt++;
          $display("frame reached word %0d without hdr_last", HDR_WORDS);
        end
      end else if (in_frame) begin
        err_cnt++;
        $display("hdr_valid dropped after %0d header words", wcnt);
        in_frame = 0;
      end
    end
  end

  initial begin : stimulus
    rst          <= 1'b1;
    tcb          <= {32'hc0a8_0114, 48'h0211_2233_4455, 16'd5001, 16'd80, 32'h7a3c_0001};
    dev          <= {32'hc0a8_0101, 48'h02aa_bbcc_ddee};
    status       <= tcp_connected;
    pld_push     <= 1'b0;
    pld_push_lng <= '0;
    pld_push_cks <= '0;
    send_ka      <= 1'b0;
    send_ack     <= 1'b0;
    ctl_send     <= 1'b0;
    ctl_flags    <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    @(posedge clk);
    expect_frame("forced_ack", 4'b0001, TCP_FLAG_ACK, tail_seq, tcb.loc_ack, 16'd0);
    send_ack <= 1'b1;
    wait_pulses(4'b0001, 1);
    end_test("forced_ack");

    push_payload("payload_0");
    push_payload("payload_1");
    push_payload("payload_2");
    @(posedge clk);
    pld_push <= 1'b0;
    wait_pulses(4'b0100, 3);
    end_test("payloads");

    @(posedge clk);
    status <= tcp_closed; // hold off the arbiter until all three requests are up
    push_payload("priority_pld");
    @(posedge clk);
    pld_push <= 1'b0;
    send_ka  <= 1'b1;
    send_ack <= 1'b1;
    expect_frame("priority_ka", 4'b0010, TCP_FLAG_ACK, tail_seq - 1, tcb.loc_ack, 16'd0);
    expect_frame("priority_ack", 4'b0001, TCP_FLAG_ACK, tail_seq, tcb.loc_ack, 16'd0);
    repeat (2) @(posedge clk);
    status <= tcp_connected;
    wait_pulses(4'b0111, 3);
    end_test("priority");

    @(posedge clk);
    status    <= tcp_closed;
    ctl_flags <= TCP_FLAG_SYN;
    ctl_send  <= 1'b1;
    expect_frame("syn", 4'b1000, TCP_FLAG_SYN, tail_seq, 32'd0, 16'd0);
    wait_pulses(4'b1000, 1);
    tail_seq = tail_seq + 32'd1; // SYN takes one sequence number
    @(posedge clk);
    status   <= tcp_connected;
    send_ack <= 1'b1;
    expect_frame("ack_after_syn", 4'b0001, TCP_FLAG_ACK, tail_seq, tcb.loc_ack, 16'd0);
    wait_pulses(4'b0001, 1);
    end_test("syn");

    @(posedge clk);
    status   <= tcp_closed;
    send_ack <= 1'b1;
    repeat (40) @(posedge clk); // nothing may come out in this window
    expect_frame("held_ack", 4'b0001, TCP_FLAG_ACK, tail_seq, tcb.loc_ack, 16'd0);
    status <= tcp_connected;
    wait_pulses(4'b0001, 1);
    end_test("ack_held_closed");

    @(posedge clk);
    status <= tcp_closed; // the queue fills while the arbiter waits
    push_payload("fill_0");
    push_payload("fill_1");
    push_payload("fill_2");
    push_payload("fill_3");
    @(posedge clk);
    pld_push <= 1'b0;
    @(negedge clk);
    full_flag_cmp("queue_full", 1'b1, pld_full);
    @(posedge clk);
    status <= tcp_connected;
    wait_pulses(4'b0100, 1);
    @(negedge clk);
    full_flag_cmp("queue_full", 1'b0, pld_full);
    wait_pulses(4'b0100, 3);
    end_test("queue_full");

    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d expected frames never came out", exp_q.size());
    end
    $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
verilog/tcp_tx_pkg.sv
verilog/tcp_tx_pld_track.sv
verilog/tcp_ctl_tx.sv
verilog/tcp_tx_arb.sv
verilog/tcp_hdr_ser.sv
verilog/tcp_tx_top.sv
dv/tcp_tx_tb.sv
